// File: design/merge_cfg_pkg.sv
package merge_cfg_pkg;

   // ############################################################
   // Beat geometry.
   // ############################################################

   localparam int LANES = 4;  // Records per beat, power of two.

   // ############################################################
   // Buffering.
   // ############################################################

   // Input side only needs to cover the source read loop.
   localparam int IN_DEPTH = 4;

   // Output side absorbs the write in flight plus sink stalls.
   localparam int OUT_DEPTH = 8;

endpackage

// File: design/merge_types_pkg.sv
package merge_types_pkg;

   // ############################################################
   // Record format.
   // ############################################################

   localparam int KEY_W     = 16;
   localparam int PAYLOAD_W = 16;
   localparam int REC_W     = KEY_W + PAYLOAD_W;  // Key low, payload high.

   typedef logic [KEY_W-1:0] key_t;
   typedef logic [REC_W-1:0] rec_t;

   // Lane 0 sits in the low bits and holds the smallest record.
   typedef logic [merge_cfg_pkg::LANES*REC_W-1:0] beat_t;

   // ############################################################
   // Field access.
   // ############################################################

   function automatic rec_t beat_rec(beat_t b, int unsigned lane);
      return b[lane*REC_W +: REC_W];
   endfunction

   function automatic key_t rec_key(rec_t r);
      return r[KEY_W-1:0];
   endfunction

endpackage

// File: design/beat_fifo.sv
module beat_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_types_pkg::beat_t i_data,
   input  logic                   i_enq,
   input  logic                   i_deq,
   output merge_types_pkg::beat_t o_data,
   output logic                   o_empty,
   output logic                   o_full,
   output logic                   o_available
);
   import merge_types_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   beat_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_enq;
   logic             do_deq;

   assign do_enq = i_enq & ~o_full;
   assign do_deq = i_deq & ~o_empty;

   assign o_data      = mem[rd_ptr];  // Show-ahead head.
   assign o_empty     = (count == '0);
   assign o_full      = (count == CNT_W'(DEPTH));
   assign o_available = (DEPTH - count) >= 2;  // Room beyond one write in flight.

   function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) wr_ptr <= next_ptr(wr_ptr);
         if (do_deq) rd_ptr <= next_ptr(rd_ptr);
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (do_enq) mem[wr_ptr] <= i_data;
   end

   // ############################################################
   // Checks on the neighbours' handshakes.
   // ############################################################

   a_no_overflow : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) i_enq |-> !o_full
   ) else $error("beat_fifo: enqueue while full.");

   a_no_underflow : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) i_deq |-> !o_empty
   ) else $error("beat_fifo: dequeue while empty.");

endmodule

// File: design/bitonic_merge_network.sv
module bitonic_merge_network (
   input  merge_types_pkg::beat_t i_lo_beat,
   input  merge_types_pkg::beat_t i_hi_beat,
   output merge_types_pkg::beat_t o_lo_beat,
   output merge_types_pkg::beat_t o_hi_beat
);
   import merge_types_pkg::*;
   import merge_cfg_pkg::*;

   localparam int NREC   = 2 * LANES;
   localparam int LEVELS = $clog2(NREC);

   rec_t stage [LEVELS+1][NREC];

   // ############################################################
   // Bitonic input and compare-exchange levels.
   // ############################################################

   always_comb begin
      // First beat ascending, second beat reversed to descend.
      for (int i = 0; i < LANES; i++) begin
         stage[0][i]         = beat_rec(i_lo_beat, i);
         stage[0][LANES + i] = beat_rec(i_hi_beat, LANES - 1 - i);
      end

      for (int l = 0; l < LEVELS; l++) begin
         for (int i = 0; i < NREC; i++) begin
            stage[l+1][i] = stage[l][i];
         end
         // Stride halves each level, from LANES down to 1.
         for (int i = 0; i < NREC; i++) begin
            if ((i & (NREC >> (l + 1))) == 0) begin
               if (rec_key(stage[l][i]) > rec_key(stage[l][i + (NREC >> (l + 1))])) begin
                  stage[l+1][i]                    = stage[l][i + (NREC >> (l + 1))];
                  stage[l+1][i + (NREC >> (l + 1))] = stage[l][i];
               end
            end
         end
      end
   end

   // ############################################################
   // Split the sorted run into two beats.
   // ############################################################

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         o_lo_beat[i*REC_W +: REC_W] = stage[LEVELS][i];
         o_hi_beat[i*REC_W +: REC_W] = stage[LEVELS][LANES + i];
      end
   end

endmodule

// File: design/merge_engine.sv
module merge_engine (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_types_pkg::beat_t i_a_head,
   input  merge_types_pkg::beat_t i_b_head,
   input  logic                   i_a_empty,
   input  logic                   i_b_empty,
   input  logic                   i_out_available,
   output logic                   o_a_deq,
   output logic                   o_b_deq,
   output logic                   o_wr,
   output merge_types_pkg::beat_t o_wr_data
);
   import merge_types_pkg::*;
   import merge_cfg_pkg::*;

   typedef enum logic [1:0] {
      PRIME,
      MERGE,
      FLUSH,
      TERM
   } state_t;

   state_t state;
   beat_t  held;       // Upper records kept from the last merge.
   beat_t  merge_in;
   beat_t  net_lo;
   beat_t  net_hi;
   logic   a_term;
   logic   b_term;
   logic   both_term;
   logic   sel_a;
   logic   step;

   // ############################################################
   // Source selection and step.
   // ############################################################

   assign a_term    = (i_a_head == '0);
   assign b_term    = (i_b_head == '0);
   assign both_term = a_term & b_term;

   // A terminator never wins; A wins ties.
   assign sel_a = b_term ? 1'b1 :
                  a_term ? 1'b0 :
                  (rec_key(beat_rec(i_a_head, 0)) <= rec_key(beat_rec(i_b_head, 0)));

   assign step     = ~i_a_empty & ~i_b_empty & i_out_available;
   assign merge_in = sel_a ? i_a_head : i_b_head;

   always_comb begin
      o_a_deq = 1'b0;
      o_b_deq = 1'b0;
      if (step) begin
         case (state)
            PRIME, MERGE: begin
               if (!both_term) begin
                  o_a_deq = sel_a;
                  o_b_deq = ~sel_a;
               end
            end
            TERM: begin
               o_a_deq = 1'b1;  // Drop both terminators.
               o_b_deq = 1'b1;
            end
            default: ;
         endcase
      end
   end

   bitonic_merge_network u_network (
      .i_lo_beat (held),
      .i_hi_beat (merge_in),
      .o_lo_beat (net_lo),
      .o_hi_beat (net_hi)
   );

   // ############################################################
   // State and registered write.
   // ############################################################

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= PRIME;
         o_wr  <= 1'b0;
      end else begin
         o_wr <= 1'b0;
         if (step) begin
            case (state)
               PRIME: state <= both_term ? TERM : MERGE;  // Empty pair skips the flush.
               MERGE: begin
                  if (both_term) state <= FLUSH;
                  else           o_wr  <= 1'b1;
               end
               FLUSH: begin
                  o_wr  <= 1'b1;
                  state <= TERM;
               end
               TERM: begin
                  o_wr  <= 1'b1;
                  state <= PRIME;
               end
               default: state <= PRIME;
            endcase
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (step) begin
         case (state)
            PRIME: held <= merge_in;
            MERGE: begin
               if (!both_term) begin
                  held      <= net_hi;
                  o_wr_data <= net_lo;
               end
            end
            FLUSH:   o_wr_data <= held;
            TERM:    o_wr_data <= '0;
            default: ;
         endcase
      end
   end

   // ############################################################
   // Checks.
   // ############################################################

   function automatic logic beat_ascending(beat_t b);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < LANES - 1; i++) begin
         if (rec_key(beat_rec(b, i)) > rec_key(beat_rec(b, i + 1))) ok = 1'b0;
      end
      return ok;
   endfunction

   a_wr_sorted : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) o_wr |-> beat_ascending(o_wr_data)
   ) else $error("merge_engine: written beat not ascending.");

   a_deq_needs_space : assert property (
      @(posedge i_clk) disable iff (!i_rst_n) (o_a_deq || o_b_deq) |-> i_out_available
   ) else $error("merge_engine: dequeue during stall.");

endmodule

// File: design/stream_merger_top.sv
module stream_merger_top (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  merge_types_pkg::beat_t i_a_data,
   input  merge_types_pkg::beat_t i_b_data,
   input  logic                   i_a_empty,
   input  logic                   i_b_empty,
   output logic                   o_a_read,
   output logic                   o_b_read,
   input  logic                   i_out_ready,
   output logic                   o_out_write,
   output merge_types_pkg::beat_t o_out_data
);
   import merge_types_pkg::*;
   import merge_cfg_pkg::*;

   beat_t a_head;
   beat_t b_head;
   beat_t wr_data;
   logic  a_empty;
   logic  b_empty;
   logic  a_full;
   logic  b_full;
   logic  a_deq;
   logic  b_deq;
   logic  wr;
   logic  out_empty;
   logic  out_available;
   logic  out_ready_q;

   // ############################################################
   // Source side.
   // ############################################################

   assign o_a_read = ~i_a_empty & ~a_full;  // Pull whenever there is room.
   assign o_b_read = ~i_b_empty & ~b_full;

   beat_fifo #(.DEPTH(IN_DEPTH)) u_fifo_a (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_data      (i_a_data),
      .i_enq       (o_a_read),
      .i_deq       (a_deq),
      .o_data      (a_head),
      .o_empty     (a_empty),
      .o_full      (a_full),
      .o_available ()
   );

   beat_fifo #(.DEPTH(IN_DEPTH)) u_fifo_b (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_data      (i_b_data),
      .i_enq       (o_b_read),
      .i_deq       (b_deq),
      .o_data      (b_head),
      .o_empty     (b_empty),
      .o_full      (b_full),
      .o_available ()
   );

   merge_engine u_engine (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_a_head        (a_head),
      .i_b_head        (b_head),
      .i_a_empty       (a_empty),
      .i_b_empty       (b_empty),
      .i_out_available (out_available),
      .o_a_deq         (a_deq),
      .o_b_deq         (b_deq),
      .o_wr            (wr),
      .o_wr_data       (wr_data)
   );

   // ############################################################
   // Sink side.
   // ############################################################

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) out_ready_q <= 1'b0;
      else          out_ready_q <= i_out_ready;
   end

   // Sink takes the head whenever this is high.
   assign o_out_write = out_ready_q & ~out_empty;

   beat_fifo #(.DEPTH(OUT_DEPTH)) u_fifo_out (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_data      (wr_data),
      .i_enq       (wr),
      .i_deq       (o_out_write),
      .o_data      (o_out_data),
      .o_empty     (out_empty),
      .o_full      (),
      .o_available (out_available)
   );

endmodule

// File: testbench/tb_stream_merger.sv
module tb_stream_merger;
   timeunit 1ns;
   timeprecision 1ps;

   import merge_types_pkg::*;
   import merge_cfg_pkg::*;

   localparam int TIMEOUT = 3000;  // Cycles per wait loop.

   typedef beat_t beat_q_t[$];
   typedef rec_t  rec_q_t[$];

   logic        i_clk;
   logic        i_rst_n;
   beat_t       i_a_data;
   beat_t       i_b_data;
   logic        i_a_empty;
   logic        i_b_empty;
   logic        o_a_read;
   logic        o_b_read;
   logic        i_out_ready;
   logic        o_out_write;
   beat_t       o_out_data;
   int          error_count;
   int          timeout_count;
   logic [31:0] rng;

   stream_merger_top UUT (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_data    (i_a_data),
      .i_b_data    (i_b_data),
      .i_a_empty   (i_a_empty),
      .i_b_empty   (i_b_empty),
      .o_a_read    (o_a_read),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_write (o_out_write),
      .o_out_data  (o_out_data)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   // ############################################################
   // Stimulus and reference model.
   // ############################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Payload is a scramble of the key, so each record is unique.
   function automatic rec_t make_record(input key_t key);
      logic [PAYLOAD_W-1:0] payload;
      payload = {key[7:0], key[15:8]} ^ 16'hc3a5;
      return {payload, key};
   endfunction

   function automatic beat_q_t pack_beats(input rec_q_t recs);
      beat_q_t beats;
      beat_t   beat;
      for (int i = 0; i < recs.size() / LANES; i++) begin
         for (int l = 0; l < LANES; l++) beat[l*REC_W +: REC_W] = recs[i*LANES + l];
         beats.push_back(beat);
      end
      beats.push_back('0);  // Terminator.
      return beats;
   endfunction

   function automatic rec_q_t unpack_records(input beat_q_t beats);
      rec_q_t recs;
      foreach (beats[i]) begin
         if (beats[i] == '0) break;
         for (int l = 0; l < LANES; l++) recs.push_back(beats[i][l*REC_W +: REC_W]);
      end
      return recs;
   endfunction

   // Two-pointer merge on key.
   function automatic beat_q_t ref_merge(input beat_q_t a, input beat_q_t b);
      rec_q_t ra;
      rec_q_t rb;
      rec_q_t merged;
      int     i;
      int     j;
      ra = unpack_records(a);
      rb = unpack_records(b);
      i  = 0;
      j  = 0;
      while (i < ra.size() || j < rb.size()) begin
         if (j >= rb.size() || (i < ra.size() && ra[i][KEY_W-1:0] < rb[j][KEY_W-1:0])) begin
            merged.push_back(ra[i]);
            i++;
         end else begin
            merged.push_back(rb[j]);
            j++;
         end
      end
      return pack_beats(merged);
   endfunction

   task automatic make_streams(input int na, input int nb, output beat_q_t a, output beat_q_t b);
      rec_q_t ra;
      rec_q_t rb;
      key_t   key;
      rec_t   rec;
      key = '0;
      while (ra.size() + rb.size() < LANES * (na + nb)) begin
         key = key + 1'b1 + key_t'(next_rand() % 7);  // Ascending and distinct.
         rec = make_record(key);
         if (ra.size() == LANES * na)      rb.push_back(rec);
         else if (rb.size() == LANES * nb) ra.push_back(rec);
         else if (next_rand() & 1)         ra.push_back(rec);
         else                              rb.push_back(rec);
      end
      a = pack_beats(ra);
      b = pack_beats(rb);
   endtask

   // ############################################################
   // Source and sink models.
   // ############################################################

   task automatic drive_source(input int side, input beat_q_t beats, input bit gaps,
                               input logic [31:0] seed);
      logic [31:0] state;
      int          idx;
      int          cycles;
      logic        gap;
      state  = seed;
      idx    = 0;
      cycles = 0;
      while (idx < beats.size()) begin
         if (cycles == TIMEOUT) begin
            $display("Timeout: source %s still holds %0d beats.", (side == 0) ? "A" : "B",
                     beats.size() - idx);
            timeout_count++;
            break;
         end
         state = xorshift32(state);
         gap   = gaps && (state[3:0] < 4'd5);
         if (side == 0) begin
            i_a_data  <= beats[idx];
            i_a_empty <= gap;
         end else begin
            i_b_data  <= beats[idx];
            i_b_empty <= gap;
         end
         @(posedge i_clk);
         if ((side == 0) ? o_a_read : o_b_read) idx++;  // Head consumed at this edge.
         cycles++;
      end
      if (side == 0) begin
         i_a_empty <= 1'b1;
         i_a_data  <= '0;
      end else begin
         i_b_empty <= 1'b1;
         i_b_data  <= '0;
      end
   endtask

   task automatic collect_output(input string name, input int n, input bit random_ready,
                                 input logic [31:0] seed, output beat_q_t got);
      logic [31:0] state;
      int          cycles;
      logic        r;
      logic        last_r;
      state  = seed;
      cycles = 0;
      last_r = i_out_ready;
      while (got.size() < n) begin
         if (cycles == TIMEOUT) begin
            $display("Timeout: %s received %0d of %0d beats.", name, got.size(), n);
            timeout_count++;
            break;
         end
         state = xorshift32(state);
         r     = random_ready ? (state[2:0] > 3'd2) : 1'b1;
         i_out_ready <= r;
         @(posedge i_clk);
         if (o_out_write) begin
            if (!last_r) begin
               $display("%s: output written one cycle after ready was low.", name);
               error_count++;
            end
            got.push_back(o_out_data);
         end
         last_r = r;
         cycles++;
      end
   endtask

   // ############################################################
   // Checks.
   // ############################################################

   task automatic check_bit(input string name, input string sig, input logic exp,
                            input logic act);
      if (act !== exp) begin
         $display("[ERROR] %s %s: expected %b, actual %b", name, sig, exp, act);
         error_count++;
      end
   endtask

   task automatic compare_beats(input string name, input beat_q_t exp, input beat_q_t got);
      if (got.size() != exp.size()) begin
         $display("[ERROR] %s beat count: expected %0d, actual %0d", name, exp.size(), got.size());
         error_count++;
      end
      for (int i = 0; i < exp.size() && i < got.size(); i++) begin
         if (got[i] !== exp[i]) begin
            $display("[ERROR] %s beat %0d: expected %h, actual %h", name, i, exp[i], got[i]);
            error_count++;
         end
      end
   endtask

   task automatic check_idle(input string name);
      i_out_ready <= 1'b1;
      repeat (16) begin
         @(posedge i_clk);
         if (o_out_write) begin
            $display("%s: extra output beat after the terminator.", name);
            error_count++;
         end
      end
   endtask

   task automatic run_streams(input string name, input beat_q_t a, input beat_q_t b,
                              input beat_q_t exp, input bit gaps, input bit bp);
      beat_q_t     got;
      logic [31:0] seed_a;
      logic [31:0] seed_b;
      logic [31:0] seed_k;
      seed_a = next_rand();
      seed_b = next_rand();
      seed_k = next_rand();
      @(posedge i_clk);
      fork
         drive_source(0, a, gaps, seed_a);
         drive_source(1, b, gaps, seed_b);
         collect_output(name, exp.size(), bp, seed_k, got);
      join
      compare_beats(name, exp, got);
      check_idle(name);
   endtask

   // ############################################################
   // Tests.
   // ############################################################

   task automatic reset_state();
      for (int i = 0; i < 8; i++) begin
         if (i == 5) i_rst_n <= 1'b1;
         @(posedge i_clk);
         check_bit("reset_state", "o_a_read", 1'b0, o_a_read);
         check_bit("reset_state", "o_b_read", 1'b0, o_b_read);
         check_bit("reset_state", "o_out_write", 1'b0, o_out_write);
      end
   endtask

   task automatic basic_merge();
      beat_q_t a;
      beat_q_t b;
      make_streams(3, 3, a, b);
      run_streams("basic_merge", a, b, ref_merge(a, b), 1'b0, 1'b0);
   endtask

   task automatic one_sided();
      beat_q_t a;
      beat_q_t b;
      make_streams(5, 0, a, b);
      run_streams("one_sided", a, b, a, 1'b0, 1'b0);  // A passes through unchanged.
   endtask

   task automatic source_gaps();
      beat_q_t a;
      beat_q_t b;
      make_streams(4, 5, a, b);
      run_streams("source_gaps", a, b, ref_merge(a, b), 1'b1, 1'b0);
   endtask

   task automatic back_pressure();
      beat_q_t a;
      beat_q_t b;
      make_streams(6, 5, a, b);
      run_streams("back_pressure", a, b, ref_merge(a, b), 1'b0, 1'b1);
   endtask

   task automatic back_to_back();
      beat_q_t a1;
      beat_q_t b1;
      beat_q_t a2;
      beat_q_t b2;
      make_streams(3, 2, a1, b1);
      make_streams(2, 4, a2, b2);
      run_streams("back_to_back", {a1, a2}, {b1, b2},
                  {ref_merge(a1, b1), ref_merge(a2, b2)}, 1'b1, 1'b0);
   endtask

   initial begin
      rng           = 32'd49;
      error_count   = 0;
      timeout_count = 0;
      i_rst_n       = 1'b0;
      i_a_data      = '0;
      i_b_data      = '0;
      i_a_empty     = 1'b1;
      i_b_empty     = 1'b1;
      i_out_ready   = 1'b1;  // Sink ready through reset.

      reset_state();
      basic_merge();
      one_sided();
      source_gaps();
      back_pressure();
      back_to_back();

      $display("Done: %0d errors, %0d timeouts.", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
design/merge_cfg_pkg.sv
design/merge_types_pkg.sv
design/beat_fifo.sv
design/bitonic_merge_network.sv
design/merge_engine.sv
design/stream_merger_top.sv
testbench/tb_stream_merger.sv
